/* design/cpuIdPkg.sv */
`default_nettype none

package cpuIdPkg;

    // Primary opcodes
    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opRegimm  = 6'b000001;
    localparam logic [5:0] opJ       = 6'b000010;
    localparam logic [5:0] opJal     = 6'b000011;
    localparam logic [5:0] opBeq     = 6'b000100;
    localparam logic [5:0] opBne     = 6'b000101;
    localparam logic [5:0] opOri     = 6'b001101;
    localparam logic [5:0] opLui     = 6'b001111;
    localparam logic [5:0] opLw      = 6'b100011;
    localparam logic [5:0] opSw      = 6'b101011;

    // SPECIAL funct codes
    localparam logic [5:0] fnJr   = 6'b001000;
    localparam logic [5:0] fnAddu = 6'b100001;
    localparam logic [5:0] fnSubu = 6'b100011;

    // REGIMM selects the branch through the rt field
    localparam logic [4:0] rtBltz = 5'b00000;
    localparam logic [4:0] rtBgez = 5'b00001;

    // Tuse is the stage distance to where an operand is consumed
    localparam logic [1:0] tuseId   = 2'd0;  // Branch compare, jr
    localparam logic [1:0] tuseEx   = 2'd1;  // ALU operands, address base
    localparam logic [1:0] tuseMem  = 2'd2;  // Store data
    localparam logic [1:0] tuseNone = 2'd3;  // Operand not read

    // Tnew is the stage distance until a result exists
    localparam logic [1:0] tnewLoad  = 2'd2;
    localparam logic [1:0] tnewAlu   = 2'd1;
    localparam logic [1:0] tnewEarly = 2'd0;  // lui and link value known in ID

    typedef enum logic [5:0] {
        kindNop = 6'd0,  // Must stay zero so a cleared bundle is a bubble
        kindAddu,
        kindSubu,
        kindOri,
        kindLui,
        kindLw,
        kindSw,
        kindBeq,
        kindBne,
        kindBgez,
        kindBltz,
        kindJ,
        kindJal,
        kindJr
    } instrKind_e;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields_s;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFields_s;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } jFields_s;

    typedef union packed {
        rFields_s    r;
        iFields_s    i;
        jFields_s    j;
        logic [31:0] raw;
    } instrWord_u;

    typedef struct packed {
        instrWord_u  instr;
        logic [31:0] pc;
    } fetchBundle_s;

    // Result of an in-flight producer, as seen from ID
    typedef struct packed {
        logic [4:0]  addr;
        logic [31:0] data;
        logic [1:0]  tnew;
    } fwdSource_s;

    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } wbWrite_s;

    typedef struct packed {
        instrKind_e  kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm16;
        logic [4:0]  shamt;
        logic [25:0] jumpTarget;
        logic [1:0]  tuseRs;
        logic [1:0]  tuseRt;
        logic [1:0]  tnew;
    } decodeInfo_s;

    typedef struct packed {
        instrKind_e  kind;
        logic [31:0] pc;
        logic [31:0] dataRs;
        logic [31:0] dataRt;
        logic [15:0] imm16;
        logic [4:0]  shamt;
        logic [4:0]  addrRs;
        logic [4:0]  addrRt;
        logic [4:0]  addrRd;
        logic [4:0]  wrAddr;
        logic [31:0] wrData;
        logic [1:0]  tnew;
    } exBundle_s;

    typedef struct packed {
        instrKind_e  kind;
        logic        cmp;
        logic [15:0] imm16;
        logic [25:0] jumpTarget;
        logic [31:0] jumpReg;
    } npcInfo_s;

endpackage

`default_nettype wire

/* design/instrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instrDecoder (
    input  cpuIdPkg::instrWord_u  word,
    output cpuIdPkg::decodeInfo_s info
);
    import cpuIdPkg::*;

    instrKind_e kind;
    logic [1:0] tuseRs;
    logic [1:0] tuseRt;
    logic [1:0] tnew;

    // Opcode first, then funct or rt for the two shared opcodes
    always_comb begin
        kind = kindNop;
        case (word.r.opcode)
            opSpecial: begin
                case (word.r.funct)
                    fnAddu:  kind = kindAddu;
                    fnSubu:  kind = kindSubu;
                    fnJr:    kind = kindJr;
                    default: kind = kindNop;  // Includes the all-zero nop
                endcase
            end
            opRegimm: begin
                case (word.i.rt)
                    rtBgez:  kind = kindBgez;
                    rtBltz:  kind = kindBltz;
                    default: kind = kindNop;
                endcase
            end
            opJ:     kind = kindJ;
            opJal:   kind = kindJal;
            opBeq:   kind = kindBeq;
            opBne:   kind = kindBne;
            opOri:   kind = kindOri;
            opLui:   kind = kindLui;
            opLw:    kind = kindLw;
            opSw:    kind = kindSw;
            default: kind = kindNop;
        endcase
    end

    // Per-kind operand demand and result latency
    always_comb begin
        tuseRs = tuseNone;
        tuseRt = tuseNone;
        tnew   = tnewEarly;
        case (kind)
            kindAddu, kindSubu: begin
                tuseRs = tuseEx;
                tuseRt = tuseEx;
                tnew   = tnewAlu;
            end
            kindOri: begin
                tuseRs = tuseEx;
                tnew   = tnewAlu;
            end
            kindLw: begin
                tuseRs = tuseEx;  // Address base
                tnew   = tnewLoad;
            end
            kindSw: begin
                tuseRs = tuseEx;
                tuseRt = tuseMem;  // Store data needed only in MEM
            end
            kindBeq, kindBne: begin
                tuseRs = tuseId;
                tuseRt = tuseId;
            end
            kindBgez, kindBltz, kindJr: tuseRs = tuseId;
            default: ;  // lui, j, jal and nop read no register
        endcase
    end

    always_comb begin
        info        = '0;
        info.tuseRs = tuseRs;
        info.tuseRt = tuseRt;
        info.tnew   = tnew;
        if (kind != kindNop) begin  // Unknown words leave all fields zero
            info.kind       = kind;
            info.rs         = word.r.rs;
            info.rt         = word.r.rt;
            info.rd         = word.r.rd;
            info.shamt      = word.r.shamt;
            info.imm16      = word.i.imm16;
            info.jumpTarget = word.j.target;
        end
    end

endmodule

`default_nettype wire

/* design/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic               clk,
    input  logic               rstN,
    input  cpuIdPkg::wbWrite_s wr,
    input  logic [4:0]         rdAddr1,
    input  logic [4:0]         rdAddr2,
    output logic [31:0]        rdData1,
    output logic [31:0]        rdData2
);
    import cpuIdPkg::*;

    logic [31:0] regs [32];

    // Register 0 is cleared by reset and never written
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && wr.addr != 5'd0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // Write-through so the value committed this edge is already visible
    function automatic logic [31:0] readPort(
        input logic [4:0]  addr,
        input logic [31:0] stored,
        input wbWrite_s    w
    );
        logic [31:0] value;
        value = stored;
        if (addr == 5'd0) begin
            value = '0;
        end else if (w.en && w.addr == addr) begin
            value = w.data;
        end
        return value;
    endfunction

    always_comb begin
        rdData1 = readPort(rdAddr1, regs[rdAddr1], wr);
        rdData2 = readPort(rdAddr2, regs[rdAddr2], wr);
    end

endmodule

`default_nettype wire

/* design/hazardUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
    input  cpuIdPkg::decodeInfo_s info,
    input  cpuIdPkg::fwdSource_s  exSrc,
    input  cpuIdPkg::fwdSource_s  memSrc,
    output logic                  stall
);
    import cpuIdPkg::*;

    logic rsHitEx;
    logic rsHitMem;
    logic rtHitEx;
    logic rtHitMem;
    logic rsWaitEx;
    logic rsWaitMem;
    logic rtWaitEx;
    logic rtWaitMem;

    // Producer writes the operand's register, zero never counts
    function automatic logic addrHit(
        input logic [4:0] addr,
        input fwdSource_s src
    );
        return (src.addr != 5'd0) && (src.addr == addr);
    endfunction

    always_comb begin
        rsHitEx  = addrHit(info.rs, exSrc);
        rsHitMem = addrHit(info.rs, memSrc);
        rtHitEx  = addrHit(info.rt, exSrc);
        rtHitMem = addrHit(info.rt, memSrc);
    end

    // Wait while the value arrives later than the operand is consumed
    // tuseNone is 3 and no Tnew exceeds 2, so unused operands never wait
    always_comb begin
        rsWaitEx  = rsHitEx  && (info.tuseRs < exSrc.tnew);
        rsWaitMem = rsHitMem && (info.tuseRs < memSrc.tnew);
        rtWaitEx  = rtHitEx  && (info.tuseRt < exSrc.tnew);
        rtWaitMem = rtHitMem && (info.tuseRt < memSrc.tnew);
    end

    assign stall = rsWaitEx | rsWaitMem | rtWaitEx | rtWaitMem;

endmodule

`default_nettype wire

/* design/idStage.sv */
`timescale 1ns/10ps
`default_nettype none

module idStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  flush,
    input  logic                  stall,
    input  cpuIdPkg::fetchBundle_s fetch,
    input  cpuIdPkg::decodeInfo_s info,
    input  logic [31:0]           rdData1,
    input  logic [31:0]           rdData2,
    input  cpuIdPkg::fwdSource_s  exSrc,
    input  cpuIdPkg::fwdSource_s  memSrc,
    output logic [4:0]            rdAddr1,
    output logic [4:0]            rdAddr2,
    output cpuIdPkg::npcInfo_s    npc,
    output cpuIdPkg::exBundle_s   exOut
);
    import cpuIdPkg::*;

    logic [31:0] opRs;
    logic [31:0] opRt;
    logic        cmp;
    logic [4:0]  wrAddr;
    logic [31:0] wrData;
    logic [1:0]  tnewNext;
    logic        loadBubble;
    exBundle_s   nextEx;

    assign rdAddr1 = info.rs;
    assign rdAddr2 = info.rt;

    // Newest producer wins, register file last
    function automatic logic [31:0] pickOperand(
        input logic [4:0]  addr,
        input logic [31:0] rfData,
        input fwdSource_s  ex,
        input fwdSource_s  mem
    );
        logic [31:0] value;
        value = rfData;
        if (addr != 5'd0 && ex.addr == addr) begin
            value = ex.data;
        end else if (addr != 5'd0 && mem.addr == addr) begin
            value = mem.data;
        end
        return value;
    endfunction

    always_comb begin
        opRs = pickOperand(info.rs, rdData1, exSrc, memSrc);
        opRt = pickOperand(info.rt, rdData2, exSrc, memSrc);
    end

    always_comb begin
        case (info.kind)
            kindBeq:  cmp = (opRs == opRt);
            kindBne:  cmp = (opRs != opRt);
            kindBgez: cmp = ~opRs[31];  // Sign bit clear
            kindBltz: cmp = opRs[31];
            default:  cmp = 1'b0;
        endcase
    end

    always_comb begin
        npc.kind       = info.kind;
        npc.cmp        = cmp;
        npc.imm16      = info.imm16;
        npc.jumpTarget = info.jumpTarget;
        npc.jumpReg    = opRs;  // jr target
    end

    // Destination register per kind
    always_comb begin
        case (info.kind)
            kindJal:            wrAddr = 5'd31;
            kindAddu, kindSubu: wrAddr = info.rd;
            kindOri, kindLui,
            kindLw:             wrAddr = info.rt;
            default:            wrAddr = 5'd0;
        endcase
    end

    // Values already known in ID travel with the instruction
    always_comb begin
        case (info.kind)
            kindJal: wrData = fetch.pc + 32'd8;     // Link past the delay slot
            kindLui: wrData = {info.imm16, 16'h0000};
            default: wrData = '0;
        endcase
    end

    // One stage closer to its result once in EX
    assign tnewNext = (info.tnew != 2'd0) ? info.tnew - 2'd1 : 2'd0;

    always_comb begin
        nextEx.kind   = info.kind;
        nextEx.pc     = fetch.pc;
        nextEx.dataRs = opRs;
        nextEx.dataRt = opRt;
        nextEx.imm16  = info.imm16;
        nextEx.shamt  = info.shamt;
        nextEx.addrRs = info.rs;
        nextEx.addrRt = info.rt;
        nextEx.addrRd = info.rd;
        nextEx.wrAddr = wrAddr;
        nextEx.wrData = wrData;
        nextEx.tnew   = tnewNext;
    end

    // Unsupported words go down the pipe as a plain bubble too
    assign loadBubble = flush | stall | (info.kind == kindNop);

    always_ff @(posedge clk) begin
        if (!rstN || loadBubble) begin
            exOut <= '0;  // kindNop with every field zero
        end else begin
            exOut <= nextEx;
        end
    end

endmodule

`default_nettype wire

/* design/cpuIdTop.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuIdTop (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   flush,
    input  cpuIdPkg::fetchBundle_s fetch,
    input  cpuIdPkg::fwdSource_s   exSrc,
    input  cpuIdPkg::fwdSource_s   memSrc,
    input  cpuIdPkg::wbWrite_s     wb,
    output cpuIdPkg::exBundle_s    exOut,
    output cpuIdPkg::npcInfo_s     npc,
    output logic                   stall
);
    import cpuIdPkg::*;

    decodeInfo_s info;
    logic [4:0]  rdAddr1;
    logic [4:0]  rdAddr2;
    logic [31:0] rdData1;
    logic [31:0] rdData2;

    instrDecoder decoder (
        .word (fetch.instr),
        .info (info)
    );

    regFile grf (
        .clk     (clk),
        .rstN    (rstN),
        .wr      (wb),
        .rdAddr1 (rdAddr1),
        .rdAddr2 (rdAddr2),
        .rdData1 (rdData1),
        .rdData2 (rdData2)
    );

    hazardUnit hazard (
        .info   (info),
        .exSrc  (exSrc),
        .memSrc (memSrc),
        .stall  (stall)
    );

    idStage stage (
        .clk     (clk),
        .rstN    (rstN),
        .flush   (flush),
        .stall   (stall),
        .fetch   (fetch),
        .info    (info),
        .rdData1 (rdData1),
        .rdData2 (rdData2),
        .exSrc   (exSrc),
        .memSrc  (memSrc),
        .rdAddr1 (rdAddr1),
        .rdAddr2 (rdAddr2),
        .npc     (npc),
        .exOut   (exOut)
    );

endmodule

`default_nettype wire

/* dv/cpuIdSva.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuIdSva (
    input logic                 clk,
    input logic                 rstN,
    input logic                 flush,
    input logic                 stall,
    input cpuIdPkg::fwdSource_s exSrc,
    input cpuIdPkg::fwdSource_s memSrc,
    input cpuIdPkg::exBundle_s  exOut
);
    import cpuIdPkg::*;

    // A held or flushed instruction leaves a bubble in ID/EX
    bubbleAfterHold: assert property (@(posedge clk) disable iff (!rstN)
        (stall || flush) |=> (exOut == '0))
        else $error("exOut is not a bubble after stall or flush");

    // Results that already exist can always be forwarded
    noStallWhenReady: assert property (@(posedge clk) disable iff (!rstN)
        (exSrc.tnew == 2'd0 && memSrc.tnew == 2'd0) |-> !stall)
        else $error("stall raised although no producer is pending");

    noWriteTarget: assert property (@(posedge clk) disable iff (!rstN)
        (exOut.kind inside {kindSw, kindBeq, kindBne, kindBgez, kindBltz, kindJ, kindJr})
        |-> (exOut.wrAddr == 5'd0))
        else $error("write address not zero for a store, branch or plain jump");

endmodule

bind cpuIdTop cpuIdSva sva (
    .clk    (clk),
    .rstN   (rstN),
    .flush  (flush),
    .stall  (stall),
    .exSrc  (exSrc),
    .memSrc (memSrc),
    .exOut  (exOut)
);

`default_nettype wire

/* dv/cpuIdTb.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuIdTb;
    import cpuIdPkg::*;

    typedef struct packed {
        exBundle_s ex;
        npcInfo_s  npc;
        logic      stall;
    } expect_s;

    localparam int stallLimit = 8;
    localparam int maxCycles  = 5000;

    logic         clk;
    logic         rstN;
    logic         flush;
    fetchBundle_s fetch;
    fwdSource_s   exSrc;
    fwdSource_s   memSrc;
    wbWrite_s     wb;
    exBundle_s    exOut;
    npcInfo_s     npc;
    logic         stall;

    logic [31:0] shadow [32];  // Register file as the testbench sees it
    exBundle_s   expEx;        // ID/EX contents expected after the coming edge
    int checks      = 0;
    int errors      = 0;
    int testChecks  = 0;
    int testErrors  = 0;
    int stallCycles = 0;

    instrKind_e decodeKinds [6] = '{kindAddu, kindSubu, kindOri, kindLui, kindLw, kindSw};
    instrKind_e branchKinds [7] = '{kindBeq, kindBne, kindBgez, kindBltz, kindJ, kindJal, kindJr};
    instrKind_e useKinds [5]    = '{kindAddu, kindBeq, kindSw, kindBltz, kindJr};

    cpuIdTop uut (
        .clk    (clk),
        .rstN   (rstN),
        .flush  (flush),
        .fetch  (fetch),
        .exSrc  (exSrc),
        .memSrc (memSrc),
        .wb     (wb),
        .exOut  (exOut),
        .npc    (npc),
        .stall  (stall)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Standard MIPS encodings
    function automatic logic [31:0] encode(input instrKind_e k, input logic [4:0] rs,
            input logic [4:0] rt, input logic [4:0] rd, input logic [15:0] imm);
        case (k)
            kindAddu: return {6'h00, rs, rt, rd, imm[10:6], 6'h21};
            kindSubu: return {6'h00, rs, rt, rd, imm[10:6], 6'h23};
            kindJr:   return {6'h00, rs, 15'd0, 6'h08};
            kindOri:  return {6'h0d, rs, rt, imm};
            kindLui:  return {6'h0f, 5'd0, rt, imm};
            kindLw:   return {6'h23, rs, rt, imm};
            kindSw:   return {6'h2b, rs, rt, imm};
            kindBeq:  return {6'h04, rs, rt, imm};
            kindBne:  return {6'h05, rs, rt, imm};
            kindBgez: return {6'h01, rs, 5'd1, imm};
            kindBltz: return {6'h01, rs, 5'd0, imm};
            kindJ:    return {6'h02, rs, rt, imm};  // Fields only fill the target
            kindJal:  return {6'h03, rs, rt, imm};
            default:  return 32'd0;
        endcase
    endfunction

    function automatic fetchBundle_s randomFetch(input instrKind_e k, input logic [4:0] rs,
            input logic [4:0] rt);
        fetchBundle_s f;
        logic [31:0]  pc;
        pc          = $urandom();
        f.pc        = {pc[31:2], 2'b00};
        f.instr.raw = encode(k, rs, rt, 5'($urandom()), 16'($urandom()));
        return f;
    endfunction

    // EX first, then MEM, then write-back, then the stored value
    function automatic logic [31:0] newestValue(input logic [4:0] addr,
            input logic [31:0] stored, input fwdSource_s ex, input fwdSource_s mem,
            input wbWrite_s w);
        if (addr == 5'd0) return 32'd0;
        if (ex.addr == addr) return ex.data;
        if (mem.addr == addr) return mem.data;
        if (w.en && w.addr == addr) return w.data;
        return stored;
    endfunction

    function automatic logic mustWait(input logic [4:0] addr, input logic [1:0] tuse,
            input fwdSource_s src);
        return (addr != 5'd0) && (src.addr == addr) && (tuse < src.tnew);
    endfunction

    function automatic expect_s refModel(input fetchBundle_s f, input fwdSource_s ex,
            input fwdSource_s mem, input wbWrite_s w, input logic fl,
            input logic [31:0] regs [32]);
        logic [31:0] raw;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [1:0]  useRs;
        logic [1:0]  useRt;
        logic [1:0]  tn;
        logic [31:0] a;
        logic [31:0] b;
        instrKind_e  k;
        expect_s     e;
        raw = f.instr.raw;
        k   = kindNop;
        case (raw[31:26])
            6'h00: begin
                if (raw[5:0] == 6'h21) k = kindAddu;
                else if (raw[5:0] == 6'h23) k = kindSubu;
                else if (raw[5:0] == 6'h08) k = kindJr;
            end
            6'h01: begin
                if (raw[20:16] == 5'd1) k = kindBgez;
                else if (raw[20:16] == 5'd0) k = kindBltz;
            end
            6'h02:   k = kindJ;
            6'h03:   k = kindJal;
            6'h04:   k = kindBeq;
            6'h05:   k = kindBne;
            6'h0d:   k = kindOri;
            6'h0f:   k = kindLui;
            6'h23:   k = kindLw;
            6'h2b:   k = kindSw;
            default: k = kindNop;
        endcase
        if (k == kindNop) raw = 32'd0;  // Unknown words decode as a bubble
        rs    = raw[25:21];
        rt    = raw[20:16];
        rd    = raw[15:11];
        useRs = 2'd3;
        useRt = 2'd3;
        tn    = 2'd0;
        case (k)
            kindAddu, kindSubu: begin
                useRs = 2'd1;
                useRt = 2'd1;
                tn    = 2'd1;
            end
            kindOri: begin
                useRs = 2'd1;
                tn    = 2'd1;
            end
            kindLw: begin
                useRs = 2'd1;
                tn    = 2'd2;
            end
            kindSw: begin
                useRs = 2'd1;
                useRt = 2'd2;  // Store data is consumed in MEM
            end
            kindBeq, kindBne: begin
                useRs = 2'd0;
                useRt = 2'd0;
            end
            kindBgez, kindBltz, kindJr: useRs = 2'd0;
            default: ;
        endcase
        a = newestValue(rs, regs[rs], ex, mem, w);
        b = newestValue(rt, regs[rt], ex, mem, w);
        e = '0;
        e.stall = mustWait(rs, useRs, ex) | mustWait(rs, useRs, mem)
                | mustWait(rt, useRt, ex) | mustWait(rt, useRt, mem);
        e.npc.kind       = k;
        e.npc.imm16      = raw[15:0];
        e.npc.jumpTarget = raw[25:0];
        e.npc.jumpReg    = a;
        case (k)
            kindBeq:  e.npc.cmp = (a == b);
            kindBne:  e.npc.cmp = (a != b);
            kindBgez: e.npc.cmp = !a[31];
            kindBltz: e.npc.cmp = a[31];
            default:  e.npc.cmp = 1'b0;
        endcase
        if (!(fl || e.stall || k == kindNop)) begin
            e.ex.kind   = k;
            e.ex.pc     = f.pc;
            e.ex.dataRs = a;
            e.ex.dataRt = b;
            e.ex.imm16  = raw[15:0];
            e.ex.shamt  = raw[10:6];
            e.ex.addrRs = rs;
            e.ex.addrRt = rt;
            e.ex.addrRd = rd;
            e.ex.tnew   = (tn == 2'd0) ? 2'd0 : tn - 2'd1;
            if (k == kindJal) e.ex.wrAddr = 5'd31;
            else if (k == kindAddu || k == kindSubu) e.ex.wrAddr = rd;
            else if (k == kindOri || k == kindLui || k == kindLw) e.ex.wrAddr = rt;
            if (k == kindJal) e.ex.wrData = f.pc + 32'd8;
            else if (k == kindLui) e.ex.wrData = {raw[15:0], 16'h0000};
        end
        return e;
    endfunction

    task automatic checkEx(input exBundle_s got, input exBundle_s exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: exOut got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic checkNpc(input npcInfo_s got, input npcInfo_s exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: npc got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic checkStall(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: stall got %b expected %b", $time, got, exp);
        end
    endtask

    // Inputs are stable at the falling edge
    always @(negedge clk) begin : compareProc
        expect_s e;
        if (rstN !== 1'b1) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] = 32'd0;
            end
            expEx = '0;
        end else begin
            e = refModel(fetch, exSrc, memSrc, wb, flush, shadow);
            checkEx(exOut, expEx);
            checkNpc(npc, e.npc);
            checkStall(stall, e.stall);
            expEx = e.ex;
            if (wb.en && wb.addr != 5'd0) shadow[wb.addr] = wb.data;  // Lands at the next edge
        end
    end

    task automatic drive(input fetchBundle_s f, input fwdSource_s ex, input fwdSource_s mem,
            input wbWrite_s w, input logic fl);
        @(posedge clk);
        fetch  <= f;
        exSrc  <= ex;
        memSrc <= mem;
        wb     <= w;
        flush  <= fl;
    endtask

    // Re-present the fetch while the producer ages toward its result
    task automatic issueWhenReady(input fetchBundle_s f, input fwdSource_s ex,
            input fwdSource_s mem);
        fwdSource_s exNow;
        fwdSource_s memNow;
        int         waited;
        exNow  = ex;
        memNow = mem;
        waited = 0;
        drive(f, exNow, memNow, '0, 1'b0);
        @(negedge clk);
        while (stall === 1'b1) begin
            if (waited == stallLimit) begin
                errors++;
                $display("stall did not release within %0d cycles at %0t", stallLimit, $time);
                break;
            end
            memNow = exNow;
            if (memNow.tnew != 2'd0) memNow.tnew = memNow.tnew - 2'd1;
            exNow = '0;
            waited++;
            stallCycles++;
            drive(f, exNow, memNow, '0, 1'b0);
            @(negedge clk);
        end
    endtask

    // One idle cycle so the last instruction's exOut is checked too
    task automatic reportTest(input int num, input string name);
        drive('0, '0, '0, '0, 1'b0);
        @(negedge clk);
        #1;
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 checks - testChecks, errors - testErrors);
        testChecks = checks;
        testErrors = errors;
    endtask

    task automatic registerReadback();
        wbWrite_s w;
        for (int i = 1; i < 32; i++) begin
            w.en   = 1'b1;
            w.addr = 5'(i);
            w.data = $urandom();
            drive(randomFetch(kindAddu, 5'(i), 5'(i - 1)), '0, '0, w, 1'b0);  // rs written now
        end
        for (int i = 0; i < 32; i++) begin
            drive(randomFetch(kindSubu, 5'(i), 5'(31 - i)), '0, '0, '0, 1'b0);
        end
        reportTest(1, "reset and register file readback");
    endtask

    task automatic decodeSweep();
        instrKind_e k;
        for (int n = 0; n < 200; n++) begin
            k = decodeKinds[$urandom_range(5, 0)];
            drive(randomFetch(k, 5'($urandom()), 5'($urandom())), '0, '0, '0, 1'b0);
        end
        reportTest(2, "ALU, ori, lui, lw and sw decode");
    endtask

    task automatic forwardingPriority();
        fwdSource_s ex;
        fwdSource_s mem;
        wbWrite_s   w;
        for (int n = 0; n < 200; n++) begin
            ex.addr  = 5'($urandom_range(3, 0));  // Few registers so addresses collide
            ex.data  = $urandom();
            ex.tnew  = 2'd0;
            mem.addr = 5'($urandom_range(3, 0));
            mem.data = $urandom();
            mem.tnew = 2'd0;
            w.en     = 1'($urandom_range(1, 0));
            w.addr   = 5'($urandom_range(3, 0));
            w.data   = $urandom();
            drive(randomFetch(kindAddu, 5'($urandom_range(3, 0)), 5'($urandom_range(3, 0))),
                  ex, mem, w, 1'b0);
        end
        reportTest(3, "forwarding priority");
    endtask

    task automatic branchAndJump();
        fwdSource_s ex;
        fwdSource_s mem;
        instrKind_e k;
        for (int n = 0; n < 200; n++) begin
            k        = branchKinds[$urandom_range(6, 0)];
            ex.addr  = 5'd1;
            ex.data  = $urandom();
            ex.tnew  = 2'd0;
            mem.addr = 5'd2;
            mem.data = $urandom_range(1, 0) ? ex.data : $urandom();  // Equal half the time
            mem.tnew = 2'd0;
            drive(randomFetch(k, 5'($urandom_range(2, 0)), 5'($urandom_range(2, 0))),
                  ex, mem, '0, 1'b0);
        end
        reportTest(4, "branch compare and jumps");
    endtask

    task automatic loadUseStall();
        fwdSource_s   load;
        fetchBundle_s f;
        logic [4:0]   r;
        logic [4:0]   rs;
        logic [4:0]   rt;
        for (int n = 0; n < 40; n++) begin
            r         = 5'($urandom_range(31, 1));
            rs        = $urandom_range(1, 0) ? r : 5'($urandom());
            rt        = $urandom_range(1, 0) ? r : 5'($urandom());
            load.addr = r;
            load.data = $urandom();
            load.tnew = tnewLoad;
            drive(randomFetch(kindLw, 5'($urandom()), r), '0, '0, '0, 1'b0);
            f = randomFetch(useKinds[$urandom_range(4, 0)], rs, rt);
            issueWhenReady(f, load, '0);
        end
        reportTest(5, "load-use stall");
    endtask

    task automatic flushBubbles();
        fwdSource_s ex;
        fwdSource_s mem;
        instrKind_e k;
        for (int n = 0; n < 100; n++) begin
            k        = instrKind_e'($urandom_range(13, 0));
            ex.addr  = 5'($urandom());
            ex.data  = $urandom();
            ex.tnew  = 2'($urandom_range(2, 0));
            mem.addr = 5'($urandom());
            mem.data = $urandom();
            mem.tnew = 2'($urandom_range(2, 0));
            drive(randomFetch(k, 5'($urandom()), 5'($urandom())), ex, mem, '0, 1'b1);
        end
        reportTest(6, "flush");
    endtask

    initial begin : watchdog
        for (int c = 0; c < maxCycles; c++) begin
            @(posedge clk);
        end
        $display("run did not finish within %0d cycles", maxCycles);
        $display("Errors found");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(32'hfd60_418a));
        rstN   = 1'b0;
        flush  = 1'b0;
        fetch  = '0;
        exSrc  = '0;
        memSrc = '0;
        wb     = '0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        registerReadback();
        decodeSweep();
        forwardingPriority();
        branchAndJump();
        loadUseStall();
        flushBubbles();
        $display("checks %0d, errors %0d, stall cycles %0d", checks, errors, stallCycles);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cpuId.f */
design/cpuIdPkg.sv
design/instrDecoder.sv
design/regFile.sv
design/hazardUnit.sv
design/idStage.sv
design/cpuIdTop.sv
dv/cpuIdSva.sv
dv/cpuIdTb.sv
